// ==== hw/rxdp_cfg_pkg.sv ====
// Receive datapath sizing: word width, FIFO depth and pointers, aligner lock and error limits
package rxdp_cfg_pkg;

    // ------------------------------
    // Lane word
    // ------------------------------
    localparam int DWIDTH = 40;

    // ------------------------------
    // FIFO geometry
    // ------------------------------
    localparam int AWIDTH     = 5;
    localparam int FIFO_DEPTH = 1 << AWIDTH;
    // Extra wrap bit on each pointer
    localparam int PTR_W      = AWIDTH + 1;
    localparam int RD_DELAY_W = 3;

    // ------------------------------
    // Word aligner
    // ------------------------------
    // Consecutive good markers before lock
    localparam int WA_LOCK_CNT = 4;
    localparam int WA_LOCK_W   = $clog2(WA_LOCK_CNT + 1);

    // Error counter saturates here
    localparam int WA_ERR_MAX = 15;
    localparam int WA_ERR_W   = 4;

endpackage

// ==== hw/rxdp_word_pkg.sv ====
// Lane word union (raw or marker plus payload) and the 80-bit packed output word
package rxdp_word_pkg;

    import rxdp_cfg_pkg::*;

    // Marker view of a lane word, mark sits in the top bit
    typedef struct packed {
        logic              mark;
        logic [DWIDTH-2:0] payload;
    } lane_fld_t;

    // Same 40 bits, seen whole by the FIFO and split by the aligner
    typedef union packed {
        logic [DWIDTH-1:0] raw;
        lane_fld_t         fld;
    } lane_word_u;

    // Output word, lo carries the earlier word of a pair
    typedef struct packed {
        logic [DWIDTH-1:0] hi;
        logic [DWIDTH-1:0] lo;
    } out_word_t;

endpackage

// ==== hw/rxdp_word_align.sv ====
// Word aligner: marker alternation check, lock detection and saturating error counter
`timescale 1ns/1ps

module rxdp_word_align
    import rxdp_cfg_pkg::*;
    import rxdp_word_pkg::*;
(
    input  logic                wr_clk,
    input  logic                rst_n,
    input  logic                r_wa_en,
    input  lane_word_u          din,
    output logic                wa_lock,
    output logic                wa_error,
    output logic [WA_ERR_W-1:0] wa_error_cnt
);

    logic                 prev_mark;
    logic                 have_prev;
    logic                 mark_ok;
    logic                 mark_bad;
    logic [WA_LOCK_W-1:0] good_cnt;

    // ------------------------------
    // Marker history
    // ------------------------------
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_mark <= 1'b0;
            have_prev <= 1'b0;
        end else begin
            prev_mark <= din.fld.mark;
            have_prev <= 1'b1;
        end
    end

    // First word after reset has nothing to compare against
    assign mark_ok  = have_prev && (din.fld.mark != prev_mark);
    assign mark_bad = have_prev && (din.fld.mark == prev_mark);

    // ------------------------------
    // Lock detection
    // ------------------------------
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            good_cnt <= '0;
            wa_lock  <= 1'b0;
        end else if (!wa_lock) begin
            if (!r_wa_en) begin
                // Bypass, every word goes through
                wa_lock <= 1'b1;
            end else if (mark_ok) begin
                if (good_cnt == WA_LOCK_W'(WA_LOCK_CNT - 1)) begin
                    wa_lock <= 1'b1;
                end else begin
                    good_cnt <= good_cnt + 1'b1;
                end
            end else begin
                good_cnt <= '0;
            end
        end
    end

    // ------------------------------
    // Errors after lock
    // ------------------------------
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            wa_error     <= 1'b0;
            wa_error_cnt <= '0;
        end else begin
            wa_error <= wa_lock && r_wa_en && mark_bad;
            if (wa_lock && r_wa_en && mark_bad &&
                (wa_error_cnt != WA_ERR_W'(WA_ERR_MAX))) begin
                wa_error_cnt <= wa_error_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== hw/rxdp_async_fifo.sv ====
// Dual-clock FIFO: gray pointers, reset synchronizers, threshold flags, phase-compensation start
`timescale 1ns/1ps

module rxdp_async_fifo
    import rxdp_cfg_pkg::*;
    import rxdp_word_pkg::*;
(
    input  logic                  wr_clk,
    input  logic                  rd_clk,
    input  logic                  rst_n,
    input  lane_word_u            din,
    input  logic                  wa_lock,
    input  logic                  r_stop_write,
    input  logic                  r_stop_read,
    input  logic [AWIDTH-1:0]     r_empty,
    input  logic [AWIDTH-1:0]     r_full,
    input  logic [AWIDTH-1:0]     r_pempty,
    input  logic [AWIDTH-1:0]     r_pfull,
    input  logic [RD_DELAY_W-1:0] r_phcomp_rd_delay,
    output lane_word_u            pop_word,
    output logic                  pop_valid,
    output logic                  rd_en_reg,
    output logic                  fifo_empty,
    output logic                  fifo_full,
    output logic                  fifo_pempty,
    output logic                  fifo_pfull
);

    logic [DWIDTH-1:0] mem [FIFO_DEPTH];

    logic [1:0]       wr_rst_sync;
    logic [1:0]       rd_rst_sync;
    logic             wr_rst_n;
    logic             rd_rst_n;

    logic [PTR_W-1:0] wr_bin;
    logic [PTR_W-1:0] wr_bin_nxt;
    logic [PTR_W-1:0] wr_gray;
    logic [PTR_W-1:0] rd_bin;
    logic [PTR_W-1:0] rd_bin_nxt;
    logic [PTR_W-1:0] rd_gray;

    // Read pointer seen in wr_clk, write pointer seen in rd_clk
    logic [PTR_W-1:0] rd_gray_w1;
    logic [PTR_W-1:0] rd_gray_w2;
    logic [PTR_W-1:0] wr_gray_r1;
    logic [PTR_W-1:0] wr_gray_r2;

    logic [PTR_W-1:0] wr_level;
    logic [PTR_W-1:0] rd_level;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] gray2bin(input logic [PTR_W-1:0] g);
        logic [PTR_W-1:0] b;
        b[PTR_W-1] = g[PTR_W-1];
        for (int i = PTR_W - 2; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    // ------------------------------
    // Reset synchronizers
    // ------------------------------
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_rst_sync <= 2'b00;
        end else begin
            wr_rst_sync <= {wr_rst_sync[0], 1'b1};
        end
    end

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_rst_sync <= 2'b00;
        end else begin
            rd_rst_sync <= {rd_rst_sync[0], 1'b1};
        end
    end

    assign wr_rst_n = wr_rst_sync[1];
    assign rd_rst_n = rd_rst_sync[1];

    // ------------------------------
    // Write side
    // ------------------------------
    assign wr_level   = wr_bin - gray2bin(rd_gray_w2);
    assign fifo_full  = wr_level >= {1'b0, r_full};
    assign fifo_pfull = wr_level >= {1'b0, r_pfull};

    // Lane cannot stall, so a full FIFO drops the word
    assign push       = wa_lock && !r_stop_write && !fifo_full;
    assign wr_bin_nxt = wr_bin + 1'b1;

    always_ff @(posedge wr_clk or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_w1 <= '0;
            rd_gray_w2 <= '0;
        end else begin
            rd_gray_w1 <= rd_gray;
            rd_gray_w2 <= rd_gray_w1;
            if (push) begin
                wr_bin  <= wr_bin_nxt;
                wr_gray <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
            end
        end
    end

    always_ff @(posedge wr_clk) begin
        if (push) begin
            mem[wr_bin[AWIDTH-1:0]] <= din.raw;
        end
    end

    // ------------------------------
    // Read side
    // ------------------------------
    assign rd_level    = gray2bin(wr_gray_r2) - rd_bin;
    assign fifo_empty  = rd_level <= {1'b0, r_empty};
    assign fifo_pempty = rd_level <= {1'b0, r_pempty};
    assign pop         = rd_en_reg && !r_stop_read && !fifo_empty;
    assign rd_bin_nxt  = rd_bin + 1'b1;

    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            wr_gray_r1 <= '0;
            wr_gray_r2 <= '0;
            rd_en_reg  <= 1'b0;
        end else begin
            wr_gray_r1 <= wr_gray;
            wr_gray_r2 <= wr_gray_r1;
            // Hold off first read until the level builds up
            if (rd_level > PTR_W'(r_phcomp_rd_delay)) begin
                rd_en_reg <= 1'b1;
            end
        end
    end

    always_ff @(posedge rd_clk or negedge rd_rst_n) begin
        if (!rd_rst_n) begin
            rd_bin    <= '0;
            rd_gray   <= '0;
            pop_valid <= 1'b0;
        end else begin
            pop_valid <= pop;
            if (pop) begin
                rd_bin  <= rd_bin_nxt;
                rd_gray <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
            end
        end
    end

    always_ff @(posedge rd_clk) begin
        if (pop) begin
            pop_word.raw <= mem[rd_bin[AWIDTH-1:0]];
        end
    end

endmodule

// ==== hw/rxdp_read_pack.sv ====
// Read packer: single or double words onto the 80-bit output with a valid strobe
`timescale 1ns/1ps

module rxdp_read_pack
    import rxdp_word_pkg::*;
(
    input  logic       rd_clk,
    input  logic       rst_n,
    input  logic       r_double_read,
    input  lane_word_u pop_word,
    input  logic       pop_valid,
    output out_word_t  data_out,
    output logic       data_valid
);

    logic       dbl_q;
    logic       phase;
    logic       phase_eff;
    lane_word_u hold_lo;

    // A mode change drops any half-built pair
    assign phase_eff = phase && (dbl_q == r_double_read);

    // ------------------------------
    // Pair phase and strobe
    // ------------------------------
    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            dbl_q      <= 1'b0;
            phase      <= 1'b0;
            data_valid <= 1'b0;
        end else begin
            dbl_q      <= r_double_read;
            phase      <= phase_eff;
            data_valid <= 1'b0;
            if (pop_valid) begin
                if (!r_double_read) begin
                    data_valid <= 1'b1;
                end else if (phase_eff) begin
                    data_valid <= 1'b1;
                    phase      <= 1'b0;
                end else begin
                    phase <= 1'b1;
                end
            end
        end
    end

    // ------------------------------
    // Output word
    // ------------------------------
    always_ff @(posedge rd_clk) begin
        if (pop_valid) begin
            if (!r_double_read) begin
                data_out.hi <= '0;
                data_out.lo <= pop_word.raw;
            end else if (phase_eff) begin
                data_out.hi <= pop_word.raw;
                data_out.lo <= hold_lo.raw;
            end else begin
                hold_lo <= pop_word;
            end
        end
    end

endmodule

// ==== hw/rxdp_top.sv ====
// Receive datapath top: word aligner, async FIFO and read packer
`timescale 1ns/1ps

module rxdp_top
    import rxdp_cfg_pkg::*;
    import rxdp_word_pkg::*;
(
    input  logic                  wr_clk,
    input  logic                  rd_clk,
    input  logic                  rst_n,
    input  lane_word_u            din,
    input  logic                  r_wa_en,
    input  logic                  r_double_read,
    input  logic                  r_stop_read,
    input  logic                  r_stop_write,
    input  logic [AWIDTH-1:0]     r_empty,
    input  logic [AWIDTH-1:0]     r_full,
    input  logic [AWIDTH-1:0]     r_pempty,
    input  logic [AWIDTH-1:0]     r_pfull,
    input  logic [RD_DELAY_W-1:0] r_phcomp_rd_delay,
    output logic                  wa_lock,
    output logic                  wa_error,
    output logic [WA_ERR_W-1:0]   wa_error_cnt,
    output logic                  align_done,
    output out_word_t             data_out,
    output logic                  data_valid,
    output logic                  fifo_empty,
    output logic                  fifo_full,
    output logic                  fifo_pempty,
    output logic                  fifo_pfull
);

    // Popped words, rd_clk domain
    lane_word_u pop_word;
    logic       pop_valid;

    rxdp_word_align u_word_align (
        .wr_clk       (wr_clk),
        .rst_n        (rst_n),
        .r_wa_en      (r_wa_en),
        .din          (din),
        .wa_lock      (wa_lock),
        .wa_error     (wa_error),
        .wa_error_cnt (wa_error_cnt)
    );

    // Phase-compensation start doubles as align_done
    rxdp_async_fifo u_async_fifo (
        .wr_clk            (wr_clk),
        .rd_clk            (rd_clk),
        .rst_n             (rst_n),
        .din               (din),
        .wa_lock           (wa_lock),
        .r_stop_write      (r_stop_write),
        .r_stop_read       (r_stop_read),
        .r_empty           (r_empty),
        .r_full            (r_full),
        .r_pempty          (r_pempty),
        .r_pfull           (r_pfull),
        .r_phcomp_rd_delay (r_phcomp_rd_delay),
        .pop_word          (pop_word),
        .pop_valid         (pop_valid),
        .rd_en_reg         (align_done),
        .fifo_empty        (fifo_empty),
        .fifo_full         (fifo_full),
        .fifo_pempty       (fifo_pempty),
        .fifo_pfull        (fifo_pfull)
    );

    rxdp_read_pack u_read_pack (
        .rd_clk        (rd_clk),
        .rst_n         (rst_n),
        .r_double_read (r_double_read),
        .pop_word      (pop_word),
        .pop_valid     (pop_valid),
        .data_out      (data_out),
        .data_valid    (data_valid)
    );

endmodule

// ==== test/rxdp_tb.sv ====
// Testbench for the receive datapath with clocks, row table, LFSR payloads, reference queue and checks
`timescale 1ns/1ps

module rxdp_tb
    import rxdp_cfg_pkg::*;
    import rxdp_word_pkg::*;
();

    localparam int N_ROWS     = 7;
    localparam int RST_CYCLES = 16;
    // Write slots held off while the FIFO reset synchronizers settle
    localparam int SETTLE     = 3;

    typedef struct packed {
        logic                  wa_en;
        logic                  dbl;
        logic [RD_DELAY_W-1:0] delay;
        logic [AWIDTH-1:0]     full;
        logic [AWIDTH-1:0]     pfull;
        logic [AWIDTH-1:0]     pempty;
        logic [7:0]            n_words;
        logic [7:0]            err_at;
        logic [7:0]            err_n;
        logic                  stop_rd;
        logic [WA_ERR_W-1:0]   exp_cnt;
    } row_t;

    logic                  wr_clk;
    logic                  rd_clk;
    logic                  rst_n;
    lane_word_u            din;
    logic                  r_wa_en;
    logic                  r_double_read;
    logic                  r_stop_read;
    logic                  r_stop_write;
    logic [AWIDTH-1:0]     r_empty;
    logic [AWIDTH-1:0]     r_full;
    logic [AWIDTH-1:0]     r_pempty;
    logic [AWIDTH-1:0]     r_pfull;
    logic [RD_DELAY_W-1:0] r_phcomp_rd_delay;
    logic                  wa_lock;
    logic                  wa_error;
    logic [WA_ERR_W-1:0]   wa_error_cnt;
    logic                  align_done;
    out_word_t             data_out;
    logic                  data_valid;
    logic                  fifo_empty;
    logic                  fifo_full;
    logic                  fifo_pempty;
    logic                  fifo_pfull;

    row_t              rows [N_ROWS];
    logic [DWIDTH-1:0] ref_q [$];
    logic [15:0]       lfsr;
    int                n_checks;
    int                n_errors;
    int                row_errors;

    rxdp_top dut (.*);

    initial begin
        wr_clk = 1'b0;
        forever #5 wr_clk = ~wr_clk;
    end

    initial begin
        rd_clk = 1'b0;
        #3;
        forever #5 rd_clk = ~rd_clk;
    end

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [DWIDTH-1:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            v[b] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_word(input string name, input out_word_t got, input out_word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            row_errors++;
            $display("Fail %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input logic [WA_ERR_W-1:0] got,
                               input logic [WA_ERR_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            row_errors++;
            $display("Fail %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            row_errors++;
            $display("Fail %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_problem(input string what);
        n_errors++;
        row_errors++;
        $display("%s", what);
    endtask

    // Output words sampled mid rd_clk period
    initial begin : collect
        out_word_t exp;
        forever begin
            @(negedge rd_clk);
            if (rst_n && data_valid) begin
                exp = '0;
                if (!align_done) begin
                    report_problem("data_valid seen while align_done is still low");
                end
                if (ref_q.size() < (r_double_read ? 2 : 1)) begin
                    report_problem("data_valid seen with no word left to deliver");
                end else begin
                    exp.lo = ref_q.pop_front();
                    if (r_double_read) begin
                        exp.hi = ref_q.pop_front();
                    end
                    check_word("data_out", data_out, exp);
                end
            end
        end
    end

    initial begin : watchdog
        longint limit;
        #1;
        limit = N_ROWS * (RST_CYCLES + 1);
        for (int k = 0; k < N_ROWS; k++) begin
            limit += rows[k].n_words * 40;
        end
        repeat (limit) @(posedge wr_clk);
        $display("Timeout, the run did not finish within %0d write clock cycles", limit);
        $display("Errors found");
        $finish;
    end

    // ------------------------------
    // Row loop
    // ------------------------------
    initial begin : main
        row_t              r;
        logic [DWIDTH-1:0] payload;
        logic              mark;
        logic              brk;
        logic              exp_err;
        logic              exp_lock;
        logic              queued;
        int                n_written;
        int                good_run;

        rst_n             = 1'b0;
        din               = '0;
        r_wa_en           = 1'b1;
        r_double_read     = 1'b0;
        r_stop_read       = 1'b0;
        r_stop_write      = 1'b1;
        r_empty           = '0;
        r_full            = 5'd31;
        r_pempty          = 5'd2;
        r_pfull           = 5'd24;
        r_phcomp_rd_delay = '0;
        n_checks          = 0;
        n_errors          = 0;
        lfsr              = 16'd28;

        // wa_en dbl delay full pfull pempty words err_at err_n stop_rd exp_cnt
        rows[0] = '{1'b1, 1'b0, 3'd2, 5'd31, 5'd24, 5'd2, 8'd25, 8'd0, 8'd0, 1'b0, 4'd0};
        rows[1] = '{1'b1, 1'b1, 3'd3, 5'd31, 5'd24, 5'd2, 8'd25, 8'd0, 8'd0, 1'b0, 4'd0};
        rows[2] = '{1'b1, 1'b0, 3'd1, 5'd31, 5'd24, 5'd2, 8'd30, 8'd12, 8'd1, 1'b0, 4'd1};
        rows[3] = '{1'b1, 1'b0, 3'd2, 5'd31, 5'd24, 5'd2, 8'd40, 8'd10, 8'd20, 1'b0, 4'd15};
        rows[4] = '{1'b0, 1'b0, 3'd0, 5'd31, 5'd24, 5'd2, 8'd24, 8'd0, 8'd0, 1'b0, 4'd0};
        rows[5] = '{1'b1, 1'b0, 3'd4, 5'd20, 5'd16, 5'd2, 8'd30, 8'd0, 8'd0, 1'b1, 4'd0};
        rows[6] = '{1'b1, 1'b1, 3'd7, 5'd31, 5'd24, 5'd2, 8'd21, 8'd0, 8'd0, 1'b0, 4'd0};

        for (int k = 0; k < N_ROWS; k++) begin
            r          = rows[k];
            row_errors = 0;
            n_written  = 0;
            ref_q.delete();
            @(negedge wr_clk);
            rst_n             = 1'b0;
            din               = '0;
            r_wa_en           = r.wa_en;
            r_double_read     = r.dbl;
            r_phcomp_rd_delay = r.delay;
            r_full            = r.full;
            r_pfull           = r.pfull;
            r_pempty          = r.pempty;
            r_stop_read       = r.stop_rd;
            r_stop_write      = 1'b1;
            repeat (RST_CYCLES) @(negedge wr_clk);
            check_flag("wa_lock", wa_lock, 1'b0);
            check_flag("align_done", align_done, 1'b0);
            check_flag("data_valid", data_valid, 1'b0);
            check_flag("fifo_empty", fifo_empty, 1'b1);
            check_flag("fifo_pempty", fifo_pempty, 1'b1);
            rst_n    = 1'b1;
            mark     = 1'b0;
            exp_err  = 1'b0;
            exp_lock = 1'b0;
            good_run = 0;

            for (int i = 0; i < r.n_words; i++) begin
                // Aligner response to the previous word
                check_flag("wa_error", wa_error, exp_err);
                check_flag("wa_lock", wa_lock, exp_lock);
                if (align_done && n_written <= r.delay) begin
                    report_problem("align_done rose before enough words were written");
                end
                brk = (i >= r.err_at) && (i < r.err_at + r.err_n);
                if (!r.wa_en) begin
                    draw_bits(1, payload);
                    mark = payload[0];
                end else if (i == 0) begin
                    mark = 1'b1;
                end else begin
                    // A break repeats the previous mark
                    mark = brk ? mark : !mark;
                end
                // Lock after WA_LOCK_CNT correct marks in a row
                if (!r.wa_en) begin
                    exp_lock = 1'b1;
                end else if (i > 0 && !brk) begin
                    good_run++;
                end else begin
                    good_run = 0;
                end
                if (good_run >= WA_LOCK_CNT) begin
                    exp_lock = 1'b1;
                end
                draw_bits(DWIDTH - 1, payload);
                exp_err      = brk && wa_lock && r.wa_en && (i > 0);
                r_stop_write = (i < SETTLE);
                queued       = wa_lock && !r_stop_write &&
                               !(r.stop_rd && n_written >= r.full);
                din.raw      = {mark, payload[DWIDTH-2:0]};
                if (queued) begin
                    ref_q.push_back(din.raw);
                    n_written++;
                end
                @(negedge wr_clk);
            end
            r_stop_write = 1'b1;
            check_flag("wa_error", wa_error, exp_err);
            check_count("wa_error_cnt", wa_error_cnt, r.exp_cnt);
            check_flag("wa_lock", wa_lock, 1'b1);

            if (r.stop_rd) begin
                repeat (6) @(negedge wr_clk);
                check_flag("fifo_full", fifo_full, 1'b1);
                check_flag("fifo_pfull", fifo_pfull, 1'b1);
                check_flag("fifo_pempty", fifo_pempty, 1'b0);
                r_stop_read = 1'b0;
            end

            while (ref_q.size() != 0) begin
                @(negedge wr_clk);
            end
            // Room for any stray output word to show up
            repeat (8) @(negedge wr_clk);
            check_flag("align_done", align_done, 1'b1);
            check_flag("fifo_empty", fifo_empty, 1'b1);
            check_flag("fifo_full", fifo_full, 1'b0);
            check_flag("fifo_pfull", fifo_pfull, 1'b0);
            $display("Row %0d: %0d words delivered, %0d mismatches", k, n_written, row_errors);
        end

        $display("Rows %0d, checks %0d, errors %0d", N_ROWS, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== src.f ====
hw/rxdp_cfg_pkg.sv
hw/rxdp_word_pkg.sv
hw/rxdp_word_align.sv
hw/rxdp_async_fifo.sv
hw/rxdp_read_pack.sv
hw/rxdp_top.sv
test/rxdp_tb.sv

// ==== Bender.yml ====
package:
  name: rxdp

sources:
  # Packages first, then RTL bottom up
  - files:
      - hw/rxdp_cfg_pkg.sv
      - hw/rxdp_word_pkg.sv
      - hw/rxdp_word_align.sv
      - hw/rxdp_async_fifo.sv
      - hw/rxdp_read_pack.sv
      - hw/rxdp_top.sv

  - target: test
    files:
      - test/rxdp_tb.sv
